//--- build.f
periph_pkg.sv
obi_reg_bridge.sv
periph_demux.sv
gpio_regs.sv
irq_ctrl.sv
peripheral_subsystem.sv
tb_peripheral_subsystem.sv

//--- Bender.yml
package:
  name: peripheral_subsystem

sources:
  - files:
      - periph_pkg.sv
      - obi_reg_bridge.sv
      - periph_demux.sv
      - gpio_regs.sv
      - irq_ctrl.sv
      - peripheral_subsystem.sv
  - target: simulation
    files:
      - tb_peripheral_subsystem.sv

//--- tb_peripheral_subsystem.sv
// Directed testbench for the peripheral subsystem
// Drives OBI accesses and answers the external register port with a stalling model
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  import periph_pkg::*;

  // About 40 accesses of under 10 cycles each, with ample margin
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic                   clk;
  logic                   rst_n;
  obi_req_t               slave_req;
  obi_rsp_t               slave_resp;
  logic [NUM_EXT_INT-1:0] intr_ext;
  logic                   irq_plic;
  logic                   msip;
  gpio_t                  gpio_in;
  gpio_t                  gpio_out;
  gpio_t                  gpio_en;
  reg_req_t               ext_req;
  reg_rsp_t               ext_rsp;

  logic   ext_ready;
  int     ext_wait;
  integer seed = 32'h06d3_6396;
  int     ext_wr_cnt;
  addr_t  ext_wr_addr;
  data_t  ext_wr_data;
  strb_t  ext_wr_strb;
  int     check_cnt;
  int     err_cnt;
  int     cycle_cnt;

  peripheral_subsystem u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .slave_req_i     (slave_req),
    .slave_resp_o    (slave_resp),
    .intr_ext_i      (intr_ext),
    .irq_plic_o      (irq_plic),
    .msip_o          (msip),
    .gpio_i          (gpio_in),
    .gpio_o          (gpio_out),
    .gpio_en_o       (gpio_en),
    .ext_slave_req_o (ext_req),
    .ext_slave_rsp_i (ext_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // External peripheral, ready comes after 0 to 3 stall cycles
  assign ext_rsp = '{rdata: ext_req.addr ^ 32'hA5A5_A5A5, error: 1'b0, ready: ext_ready};

  always @(posedge clk) begin
    if (!rst_n) begin
      ext_wait = $random(seed) & 3;
    end else if (ext_req.valid && ext_ready) begin
      if (ext_req.write) begin
        ext_wr_cnt++;
        ext_wr_addr = ext_req.addr;
        ext_wr_data = ext_req.wdata;
        ext_wr_strb = ext_req.wstrb;
      end
      ext_wait = $random(seed) & 3;
    end else if (ext_req.valid) begin
      ext_wait = ext_wait - 1;
    end
    #2;
    ext_ready = (ext_wait == 0);
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input string name, input data_t actual, input data_t expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
    end
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            input strb_t be, output data_t rdata, output logic err);
    @(posedge clk);
    #2;
    slave_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(posedge clk);
    while (!slave_resp.gnt) @(posedge clk);
    #2;
    slave_req = '0;
    @(posedge clk);
    while (!slave_resp.rvalid) @(posedge clk);
    rdata = slave_resp.rdata;
    err   = slave_resp.err;
  endtask

  task automatic obi_write(input addr_t addr, input data_t wdata, input strb_t be);
    data_t rd;
    logic  err;
    bus_access(1'b1, addr, wdata, be, rd, err);
    check_value("write err", data_t'(err), 32'h0);
  endtask

  task automatic obi_read(input addr_t addr, output data_t rdata, output logic err);
    bus_access(1'b0, addr, '0, 4'hF, rdata, err);
  endtask

  task automatic read_expect(input string name, input addr_t addr, input data_t expected);
    data_t rd;
    logic  err;
    obi_read(addr, rd, err);
    check_value(name, rd, expected);
    check_value("read err", data_t'(err), 32'h0);
  endtask

  task automatic reset_values_test();
    check_value("irq_plic_o", data_t'(irq_plic), 32'h0);
    check_value("msip_o", data_t'(msip), 32'h0);
    check_value("gpio_o", data_t'(gpio_out), 32'h0);
    check_value("gpio_en_o", data_t'(gpio_en), 32'h0);
    check_value("ext_slave_req_o.valid", data_t'(ext_req.valid), 32'h0);
    read_expect("GPIO_OUT", GPIO_BASE + GPIO_OUT, 32'h0);
  endtask

  task automatic gpio_out_oe_test();
    obi_write(GPIO_BASE + GPIO_OUT, 32'h0000_005A, 4'hF);
    read_expect("GPIO_OUT", GPIO_BASE + GPIO_OUT, 32'h0000_005A);
    check_value("gpio_o", data_t'(gpio_out), 32'h5A);
    obi_write(GPIO_BASE + GPIO_OE, 32'hFFFF_FF3C, 4'hF);
    read_expect("GPIO_OE", GPIO_BASE + GPIO_OE, 32'h0000_003C);
    check_value("gpio_en_o", data_t'(gpio_en), 32'h3C);
    // Only byte 0 reaches the 8-bit register
    obi_write(GPIO_BASE + GPIO_OUT, 32'h1234_56C3, 4'b0001);
    read_expect("GPIO_OUT", GPIO_BASE + GPIO_OUT, 32'h0000_00C3);
    obi_write(GPIO_BASE + GPIO_OUT, 32'hFFFF_FF00, 4'b1110);
    read_expect("GPIO_OUT", GPIO_BASE + GPIO_OUT, 32'h0000_00C3);
    check_value("gpio_o", data_t'(gpio_out), 32'hC3);
  endtask

  task automatic gpio_irq_test();
    data_t id;
    id = GPIO_IRQ_BASE + 2;
    obi_write(GPIO_BASE + GPIO_IE, 32'h0000_0004, 4'hF);
    obi_write(IRQ_BASE + IRQ_ENABLE, data_t'(1) << id, 4'hF);
    @(posedge clk);
    #2;
    gpio_in = 8'h04;
    read_expect("GPIO_IN", GPIO_BASE + GPIO_IN, 32'h0000_0004);
    read_expect("GPIO_IS", GPIO_BASE + GPIO_IS, 32'h0000_0004);
    read_expect("IRQ_PENDING", IRQ_BASE + IRQ_PENDING, data_t'(1) << id);
    check_value("irq_plic_o", data_t'(irq_plic), 32'h1);
    read_expect("IRQ_CLAIM", IRQ_BASE + IRQ_CLAIM, id);
    check_value("irq_plic_o", data_t'(irq_plic), 32'h0);
    obi_write(GPIO_BASE + GPIO_IS, 32'h0000_0004, 4'hF);
    read_expect("GPIO_IS", GPIO_BASE + GPIO_IS, 32'h0);
    #2;
    gpio_in = 8'h00;
  endtask

  task automatic ext_irq_test();
    obi_write(IRQ_BASE + IRQ_ENABLE, (data_t'(1) << (EXT_IRQ_BASE + 1)) |
              (data_t'(1) << (EXT_IRQ_BASE + 3)), 4'hF);
    @(posedge clk);
    #2;
    intr_ext = 4'b1010;
    read_expect("IRQ_PENDING", IRQ_BASE + IRQ_PENDING, 32'h0000_1400);
    check_value("irq_plic_o", data_t'(irq_plic), 32'h1);
    read_expect("IRQ_CLAIM", IRQ_BASE + IRQ_CLAIM, EXT_IRQ_BASE + 1);
    read_expect("IRQ_CLAIM", IRQ_BASE + IRQ_CLAIM, EXT_IRQ_BASE + 3);
    read_expect("IRQ_CLAIM", IRQ_BASE + IRQ_CLAIM, 32'h0);
    check_value("irq_plic_o", data_t'(irq_plic), 32'h0);
    // Line 0 stays disabled
    #2;
    intr_ext = 4'b1011;
    read_expect("IRQ_PENDING", IRQ_BASE + IRQ_PENDING, data_t'(1) << EXT_IRQ_BASE);
    check_value("irq_plic_o", data_t'(irq_plic), 32'h0);
    read_expect("IRQ_CLAIM", IRQ_BASE + IRQ_CLAIM, 32'h0);
    obi_write(IRQ_BASE + IRQ_MSIP, 32'h0000_0001, 4'b0001);
    check_value("msip_o", data_t'(msip), 32'h1);
    read_expect("IRQ_MSIP", IRQ_BASE + IRQ_MSIP, 32'h1);
    obi_write(IRQ_BASE + IRQ_MSIP, 32'h0000_0000, 4'b0001);
    check_value("msip_o", data_t'(msip), 32'h0);
    #2;
    intr_ext = '0;
  endtask

  task automatic ext_port_test();
    addr_t addr;
    data_t rd;
    logic  err;
    int    prev;
    for (int i = 0; i < 8; i++) begin
      addr = EXT_BASE + 4 * i;
      read_expect("ext rdata", addr, addr ^ 32'hA5A5_A5A5);
    end
    prev = ext_wr_cnt;
    obi_write(EXT_BASE + 32'h10, 32'hDEAD_BEEF, 4'b0110);
    check_value("ext write count", ext_wr_cnt, prev + 1);
    check_value("ext_slave_req_o.addr", ext_wr_addr, EXT_BASE + 32'h10);
    check_value("ext_slave_req_o.wdata", ext_wr_data, 32'hDEAD_BEEF);
    check_value("ext_slave_req_o.wstrb", data_t'(ext_wr_strb), 32'h6);
    obi_read(32'h0000_3000, rd, err);
    check_value("unmapped err", data_t'(err), 32'h1);
    check_value("unmapped rdata", rd, 32'h0);
  endtask

  initial begin
    rst_n      = 1'b0;
    slave_req  = '0;
    intr_ext   = '0;
    gpio_in    = '0;
    ext_ready  = 1'b0;
    ext_wr_cnt = 0;
    check_cnt  = 0;
    err_cnt    = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_values_test();
    gpio_out_oe_test();
    gpio_irq_test();
    ext_irq_test();
    ext_port_test();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- peripheral_subsystem.sv
// Peripheral subsystem top level
// OBI slave port in, GPIO, interrupt controller and an external register port behind it
`timescale 1ns/1ps

module peripheral_subsystem (
  input  logic                               clk_i,
  input  logic                               rst_n_i,

  input  periph_pkg::obi_req_t               slave_req_i,
  output periph_pkg::obi_rsp_t               slave_resp_o,

  // Interrupts
  input  logic [periph_pkg::NUM_EXT_INT-1:0] intr_ext_i,
  output logic                               irq_plic_o,
  output logic                               msip_o,

  // GPIO pins
  input  periph_pkg::gpio_t                  gpio_i,
  output periph_pkg::gpio_t                  gpio_o,
  output periph_pkg::gpio_t                  gpio_en_o,

  // External peripheral port
  output periph_pkg::reg_req_t               ext_slave_req_o,
  input  periph_pkg::reg_rsp_t               ext_slave_rsp_i
);

  import periph_pkg::*;

  reg_req_t bus_req;
  reg_rsp_t bus_rsp;
  reg_req_t irq_req;
  reg_rsp_t irq_rsp;
  reg_req_t gpio_req;
  reg_rsp_t gpio_rsp;
  gpio_t    gpio_intr;

  obi_reg_bridge u_bridge (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .obi_req_i (slave_req_i),
    .obi_rsp_o (slave_resp_o),
    .reg_req_o (bus_req),
    .reg_rsp_i (bus_rsp)
  );

  periph_demux u_demux (
    .reg_req_i  (bus_req),
    .reg_rsp_o  (bus_rsp),
    .irq_req_o  (irq_req),
    .irq_rsp_i  (irq_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .ext_req_o  (ext_slave_req_o),
    .ext_rsp_i  (ext_slave_rsp_i)
  );

  gpio_regs u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_req_i (gpio_req),
    .reg_rsp_o (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  irq_ctrl u_irq (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (irq_req),
    .reg_rsp_o   (irq_rsp),
    .gpio_intr_i (gpio_intr),
    .ext_intr_i  (intr_ext_i),
    .irq_o       (irq_plic_o),
    .msip_o      (msip_o)
  );

endmodule

//--- irq_ctrl.sv
// Platform interrupt controller with pending, enable, claim and software interrupt
// Source 0 is reserved, so a claim of 0 means nothing is pending
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  output periph_pkg::reg_rsp_t              reg_rsp_o,
  input  periph_pkg::gpio_t                 gpio_intr_i,
  input  logic [periph_pkg::NUM_EXT_INT-1:0] ext_intr_i,
  output logic                              irq_o,
  output logic                              msip_o
);

  import periph_pkg::*;

  irq_src_t src;
  irq_src_t src_q;
  irq_src_t pending_q;
  irq_src_t enable_q;
  irq_src_t claim_clr;
  irq_id_t  claim_id;
  logic     msip_q;
  logic     wr_en;
  logic     claim_rd;
  reg_off_t off;
  data_t    rdata;

  // Unused source numbers stay tied low
  always_comb begin
    src = '0;
    src[GPIO_IRQ_BASE +: GPIO_WIDTH] = gpio_intr_i;
    src[EXT_IRQ_BASE +: NUM_EXT_INT] = ext_intr_i;
  end

  assign off      = reg_req_i.addr[REGION_LSB-1:0];
  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign claim_rd = reg_req_i.valid & ~reg_req_i.write & (off == IRQ_CLAIM);

  // Lowest enabled pending id wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (pending_q[i] & enable_q[i]) claim_id = irq_id_t'(i);
    end
  end

  assign claim_clr = claim_rd ? (irq_src_t'(1) << claim_id) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      src_q     <= src;
      pending_q <= (pending_q & ~claim_clr) | (src & ~src_q);
      if (wr_en && off == IRQ_ENABLE) begin
        enable_q <= irq_src_t'(apply_wstrb(data_t'(enable_q), reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr_en && off == IRQ_MSIP && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (off)
      IRQ_PENDING: rdata[NUM_SRC-1:0] = pending_q;
      IRQ_ENABLE:  rdata[NUM_SRC-1:0] = enable_q;
      IRQ_CLAIM:   rdata[$bits(irq_id_t)-1:0] = claim_id;
      IRQ_MSIP:    rdata[0] = msip_q;
      default: ;
    endcase
  end

  assign reg_rsp_o = '{rdata: rdata, error: 1'b0, ready: 1'b1};
  assign irq_o     = |(pending_q & enable_q);
  assign msip_o    = msip_q;

endmodule

//--- gpio_regs.sv
// GPIO register block with output, output enable and edge interrupt registers
// Inputs pass a two-stage synchronizer before use
`timescale 1ns/1ps

module gpio_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  periph_pkg::gpio_t    gpio_i,
  output periph_pkg::gpio_t    gpio_o,
  output periph_pkg::gpio_t    gpio_en_o,
  output periph_pkg::gpio_t    intr_o
);

  import periph_pkg::*;

  gpio_t    sync_q1, sync_q2, prev_q;
  gpio_t    out_q, oe_q, ie_q, is_q;
  gpio_t    rise;
  gpio_t    is_clr;
  logic     wr_en;
  reg_off_t off;
  data_t    rdata;

  assign off   = reg_req_i.addr[REGION_LSB-1:0];
  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign rise  = sync_q2 & ~prev_q;

  // Write ones to clear, byte enables respected
  assign is_clr = (wr_en && off == GPIO_IS) ?
                  gpio_t'(apply_wstrb('0, reg_req_i.wdata, reg_req_i.wstrb)) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      is_q    <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      is_q    <= (is_q & ~is_clr) | rise;
      if (wr_en) begin
        case (off)
          GPIO_OUT: out_q <= gpio_t'(apply_wstrb(data_t'(out_q), reg_req_i.wdata, reg_req_i.wstrb));
          GPIO_OE:  oe_q  <= gpio_t'(apply_wstrb(data_t'(oe_q), reg_req_i.wdata, reg_req_i.wstrb));
          GPIO_IE:  ie_q  <= gpio_t'(apply_wstrb(data_t'(ie_q), reg_req_i.wdata, reg_req_i.wstrb));
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (off)
      GPIO_IN:  rdata[GPIO_WIDTH-1:0] = sync_q2;
      GPIO_OUT: rdata[GPIO_WIDTH-1:0] = out_q;
      GPIO_OE:  rdata[GPIO_WIDTH-1:0] = oe_q;
      GPIO_IE:  rdata[GPIO_WIDTH-1:0] = ie_q;
      GPIO_IS:  rdata[GPIO_WIDTH-1:0] = is_q;
      default: ;
    endcase
  end

  assign reg_rsp_o = '{rdata: rdata, error: 1'b0, ready: 1'b1};
  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = is_q & ie_q;

endmodule

//--- periph_demux.sv
// Address decode for the register bus
// Routes each access to the interrupt controller, GPIO or external port
`timescale 1ns/1ps

module periph_demux (
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output periph_pkg::reg_req_t irq_req_o,
  input  periph_pkg::reg_rsp_t irq_rsp_i,
  output periph_pkg::reg_req_t gpio_req_o,
  input  periph_pkg::reg_rsp_t gpio_rsp_i,
  output periph_pkg::reg_req_t ext_req_o,
  input  periph_pkg::reg_rsp_t ext_rsp_i
);

  import periph_pkg::*;

  logic sel_irq;
  logic sel_gpio;
  logic sel_ext;

  assign sel_irq  = reg_req_i.addr[31:REGION_LSB] == IRQ_BASE[31:REGION_LSB];
  assign sel_gpio = reg_req_i.addr[31:REGION_LSB] == GPIO_BASE[31:REGION_LSB];
  assign sel_ext  = reg_req_i.addr[31:REGION_LSB] == EXT_BASE[31:REGION_LSB];

  // Same request to all targets, valid only at the selected one
  always_comb begin
    irq_req_o        = reg_req_i;
    irq_req_o.valid  = reg_req_i.valid & sel_irq;
    gpio_req_o       = reg_req_i;
    gpio_req_o.valid = reg_req_i.valid & sel_gpio;
    ext_req_o        = reg_req_i;
    ext_req_o.valid  = reg_req_i.valid & sel_ext;
  end

  always_comb begin
    if (sel_irq) begin
      reg_rsp_o = irq_rsp_i;
    end else if (sel_gpio) begin
      reg_rsp_o = gpio_rsp_i;
    end else if (sel_ext) begin
      reg_rsp_o = ext_rsp_i;
    end else begin
      // Unmapped, answered here
      reg_rsp_o = '{rdata: '0, error: 1'b1, ready: 1'b1};
    end
  end

endmodule

//--- obi_reg_bridge.sv
// OBI slave to register bus bridge holding one access in flight
// Grants a new request in the cycle the held access completes
`timescale 1ns/1ps

module obi_reg_bridge (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  periph_pkg::obi_req_t obi_req_i,
  output periph_pkg::obi_rsp_t obi_rsp_o,
  output periph_pkg::reg_req_t reg_req_o,
  input  periph_pkg::reg_rsp_t reg_rsp_i
);

  import periph_pkg::*;

  logic  valid_q;
  logic  write_q;
  addr_t addr_q;
  data_t wdata_q;
  strb_t wstrb_q;
  logic  rvalid_q;
  data_t rdata_q;
  logic  err_q;
  logic  done;
  logic  gnt;

  assign done = valid_q & reg_rsp_i.ready;
  // Idle, or the held access finishes this cycle
  assign gnt  = obi_req_i.req & (~valid_q | reg_rsp_i.ready);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      if (gnt) begin
        valid_q <= 1'b1;
      end else if (done) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      write_q <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
      wstrb_q <= obi_req_i.be;
    end
    if (done) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  assign reg_req_o = '{valid: valid_q, write: write_q, addr: addr_q,
                       wdata: wdata_q, wstrb: wstrb_q};
  assign obi_rsp_o = '{gnt: gnt, rvalid: rvalid_q, rdata: rdata_q, err: err_q};

endmodule

//--- periph_pkg.sv
// Bus types, sizes, address map and register offsets for the peripheral subsystem
// Modules pull these in with a wildcard import and use scoped names in their port lists
package periph_pkg;

  localparam int unsigned GPIO_WIDTH    = 8;
  localparam int unsigned NUM_SRC       = 16;
  localparam int unsigned NUM_EXT_INT   = 4;
  localparam int unsigned GPIO_IRQ_BASE = 1;
  localparam int unsigned EXT_IRQ_BASE  = 9;

  // Regions are 4 KiB, decoded on bits 31:12
  localparam int unsigned REGION_LSB = 12;

  typedef logic [31:0]             addr_t;
  typedef logic [31:0]             data_t;
  typedef logic [3:0]              strb_t;
  typedef logic [GPIO_WIDTH-1:0]   gpio_t;
  typedef logic [NUM_SRC-1:0]      irq_src_t;
  typedef logic [3:0]              irq_id_t;
  typedef logic [REGION_LSB-1:0]   reg_off_t;

  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } obi_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
    logic  ready;
  } reg_rsp_t;

  localparam addr_t IRQ_BASE  = 32'h0000_0000;
  localparam addr_t GPIO_BASE = 32'h0000_1000;
  localparam addr_t EXT_BASE  = 32'h0000_2000;

  localparam reg_off_t GPIO_IN  = 12'h000;
  localparam reg_off_t GPIO_OUT = 12'h004;
  localparam reg_off_t GPIO_OE  = 12'h008;
  localparam reg_off_t GPIO_IE  = 12'h00C;
  localparam reg_off_t GPIO_IS  = 12'h010;

  localparam reg_off_t IRQ_PENDING = 12'h000;
  localparam reg_off_t IRQ_ENABLE  = 12'h004;
  localparam reg_off_t IRQ_CLAIM   = 12'h008;
  localparam reg_off_t IRQ_MSIP    = 12'h00C;

  // Byte-wise merge of write data into an old register value
  function automatic data_t apply_wstrb(data_t old_v, data_t new_v, strb_t strb);
    data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
    end
    return res;
  endfunction

endpackage
